/* mipsControl.f */
hw/controlPkg.sv
hw/instrDecode.sv
hw/execSequencer.sv
hw/resultControl.sv
hw/controlUnit.sv
dv/controlUnitTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = controlUnitTb
FILELIST = mipsControl.f
PASSMSG  = TEST PASS

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf obj_dir

/* dv/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

    localparam int MemLatency = 2;
    localparam int RepeatCount = 2;
    localparam int NumTests = 14;
    localparam int TimeoutCycles = NumTests * (MemLatency + 8) * RepeatCount + 50;

    // How an instruction leaves the sequencer
    localparam int kindWrite = 0;
    localparam int kindTrap = 1;
    localparam int kindBreak = 2;
    localparam int kindRte = 3;

    logic                 clock;
    logic                 reset;
    controlPkg::instrWord instr;
    logic                 overflow;
    controlPkg::dpControl dp;
    controlPkg::wbControl wb;

    logic [31:0] lfsrState;
    int          cycleCount;
    int          passCount;
    int          failCount;

    controlUnit #(
        .MemLatency (MemLatency)
    ) i_controlUnit (
        .clock    (clock),
        .reset    (reset),
        .instr    (instr),
        .overflow (overflow),
        .dp       (dp),
        .wb       (wb)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run did not finish within %0d cycles", TimeoutCycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic controlPkg::instrWord rWord(input logic [5:0] funct);
        controlPkg::instrWord w;
        w.rType.opcode = controlPkg::opR;
        w.rType.rs = 5'(takeBits(5));
        w.rType.rt = 5'(takeBits(5));
        w.rType.rd = 5'(takeBits(5));
        w.rType.shamt = '0;
        w.rType.funct = funct;
        return w;
    endfunction

    function automatic controlPkg::instrWord iWord(input logic [5:0] opcode);
        controlPkg::instrWord w;
        w.iType.opcode = opcode;
        w.iType.rs = 5'(takeBits(5));
        w.iType.rt = 5'(takeBits(5));
        w.iType.immediate = takeBits(16);
        return w;
    endfunction

    // Datapath controls k cycles after fetch issue
    function automatic controlPkg::dpControl expectDp(input int k, input int kind,
            input controlPkg::aluOpType aluOp, input controlPkg::aluSrcBType srcB);
        controlPkg::dpControl d;
        d = '0;
        if (k <= MemLatency + 1) begin
            d.aluSrcA = controlPkg::srcApc;
            d.aluSrcB = controlPkg::srcBfour;
            d.aluOp = controlPkg::aluAdd;
            d.pcSource = controlPkg::pcAluResult;
        end
        if (k == MemLatency) begin
            d.irWrite = 1'b1;
            d.pcWrite = 1'b1;
        end
        if (k == MemLatency + 1) begin
            d.regAWrite = 1'b1;
            d.regBWrite = 1'b1;
            d.aluOutWrite = 1'b1;
        end
        if (k == MemLatency + 2) begin
            d.aluSrcA = controlPkg::srcApc;
            d.aluSrcB = controlPkg::srcBbranchOffset;
            d.aluOp = controlPkg::aluAdd;
        end
        if (k == MemLatency + 4) begin
            if (kind == kindBreak) begin
                d.pcWrite = 1'b1;
                d.pcSource = controlPkg::pcAluResult;
                d.aluSrcA = controlPkg::srcApc;
                d.aluSrcB = controlPkg::srcBfour;
                d.aluOp = controlPkg::aluSub;
            end else if (kind == kindRte) begin
                d.pcWrite = 1'b1;
                d.pcSource = controlPkg::pcEpc;
            end else begin
                d.aluSrcA = controlPkg::srcAregA;
                d.aluSrcB = srcB;
                d.aluOp = aluOp;
                d.aluOutWrite = 1'b1;
            end
        end
        if (k == MemLatency + 7 && kind == kindTrap) begin
            d.pcWrite = 1'b1;
            d.pcSource = controlPkg::pcExcVector;
        end
        return d;
    endfunction

    task automatic reportTest(input string name, input int errs);
        if (errs == 0) begin
            passCount++;
            $display("%-12s passed", name);
        end else begin
            failCount++;
            $display("%-12s failed with %0d errors", name, errs);
        end
    endtask

    // Reset held over three rising edges, all outputs quiet
    task automatic resetQuiet();
        int errs;
        int i;
        errs = 0;
        for (i = 0; i < 3; i++) begin
            @(posedge clock);
            if (i == 2) begin
                reset <= 1'b0;
            end
            @(negedge clock);
            if (dp !== '0 || wb !== '0) begin
                errs++;
                $display("ERROR resetQuiet expected %h %h actual %h %h", '0, '0, dp, wb);
            end
        end
        reportTest("resetQuiet", errs);
    endtask

    // One instruction from its fetch issue up to the next fetch issue
    task automatic runInstr(input string name, input controlPkg::instrWord w, input logic ov,
            input int kind, input controlPkg::aluOpType aluOp,
            input controlPkg::aluSrcBType srcB, input controlPkg::regDstType dst,
            input controlPkg::excCause cause);
        controlPkg::dpControl expDp;
        controlPkg::wbControl expWb;
        int                   lastStep;
        int                   errs;
        int                   k;
        errs = 0;
        lastStep = MemLatency + 4;
        if (kind == kindWrite) begin
            lastStep = MemLatency + 6;
        end else if (kind == kindTrap) begin
            lastStep = MemLatency + 7;
        end
        for (k = 0; k <= lastStep; k++) begin
            @(posedge clock);
            // Instruction after the IR load, flag before retire
            if (k == MemLatency + 1) begin
                instr <= w;
            end
            if (k == MemLatency + 4) begin
                overflow <= ov;
            end
            @(negedge clock);
            expDp = expectDp(k, kind, aluOp, srcB);
            expWb = '0;
            if (k == MemLatency + 6 && kind == kindWrite) begin
                expWb.regWrite = 1'b1;
                expWb.regDst = dst;
            end
            if (k == MemLatency + 6 && kind == kindTrap) begin
                expWb.epcWrite = 1'b1;
                expWb.cause = cause;
            end
            if (dp !== expDp) begin
                errs++;
                $display("ERROR %s dp at step %0d expected %h actual %h", name, k, expDp, dp);
            end
            if (wb !== expWb) begin
                errs++;
                $display("ERROR %s wb at step %0d expected %h actual %h", name, k, expWb, wb);
            end
        end
        reportTest(name, errs);
    endtask

    initial begin
        int round;
        clock = 1'b0;
        reset = 1'b1;
        instr = '0;
        overflow = 1'b0;
        lfsrState = 32'd88404;
        cycleCount = 0;
        passCount = 0;
        failCount = 0;
        resetQuiet();
        for (round = 0; round < RepeatCount; round++) begin
            runInstr("add", rWord(controlPkg::functAdd), 1'b0, kindWrite, controlPkg::aluAdd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("sub", rWord(controlPkg::functSub), 1'b0, kindWrite, controlPkg::aluSub,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("and", rWord(controlPkg::functAnd), 1'b0, kindWrite, controlPkg::aluAnd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("addi", iWord(controlPkg::opAddi), 1'b0, kindWrite, controlPkg::aluAdd,
                controlPkg::srcBimm, controlPkg::dstRt, controlPkg::causeOverflow);
            runInstr("addiu", iWord(controlPkg::opAddiu), 1'b0, kindWrite, controlPkg::aluAdd,
                controlPkg::srcBimm, controlPkg::dstRt, controlPkg::causeOverflow);
            runInstr("addiuOvf", iWord(controlPkg::opAddiu), 1'b1, kindWrite, controlPkg::aluAdd,
                controlPkg::srcBimm, controlPkg::dstRt, controlPkg::causeOverflow);
            runInstr("addiOvf", iWord(controlPkg::opAddi), 1'b1, kindTrap, controlPkg::aluAdd,
                controlPkg::srcBimm, controlPkg::dstRt, controlPkg::causeOverflow);
            runInstr("addOvf", rWord(controlPkg::functAdd), 1'b1, kindTrap, controlPkg::aluAdd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("subOvf", rWord(controlPkg::functSub), 1'b1, kindTrap, controlPkg::aluSub,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("andOvf", rWord(controlPkg::functAnd), 1'b1, kindWrite, controlPkg::aluAnd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("break", rWord(controlPkg::functBreak), 1'b0, kindBreak, controlPkg::aluSub,
                controlPkg::srcBfour, controlPkg::dstRd, controlPkg::causeOverflow);
            runInstr("rte", rWord(controlPkg::functRte), 1'b0, kindRte, controlPkg::aluAdd,
                controlPkg::srcBfour, controlPkg::dstRd, controlPkg::causeOverflow);
            // Unused opcode and unused funct, decoded with the R-type defaults
            runInstr("badOpcode", iWord(6'b010101), 1'b0, kindTrap, controlPkg::aluAdd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeIllegal);
            runInstr("badFunct", rWord(6'b000111), 1'b1, kindTrap, controlPkg::aluAdd,
                controlPkg::srcBregB, controlPkg::dstRd, controlPkg::causeIllegal);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit #(
    parameter int MemLatency = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  controlPkg::instrWord instr,
    input  logic                 overflow,
    output controlPkg::dpControl dp,
    output controlPkg::wbControl wb
);

    // Decoded view of the current instruction
    controlPkg::decodedOp op;

    // Sequencer to result handshake
    logic retireStep;
    logic trap;

    instrDecode i_instrDecode (
        .instr (instr),
        .op    (op)
    );

    execSequencer #(
        .MemLatency (MemLatency)
    ) i_execSequencer (
        .clock      (clock),
        .reset      (reset),
        .op         (op),
        .trap       (trap),
        .dp         (dp),
        .retireStep (retireStep)
    );

    resultControl i_resultControl (
        .clock      (clock),
        .reset      (reset),
        .op         (op),
        .overflow   (overflow),
        .retireStep (retireStep),
        .wb         (wb),
        .trap       (trap)
    );

endmodule

/* hw/resultControl.sv */
`timescale 1ns/1ps

module resultControl (
    input  logic                 clock,
    input  logic                 reset,
    input  controlPkg::decodedOp op,
    input  logic                 overflow,
    input  logic                 retireStep,
    output controlPkg::wbControl wb,
    output logic                 trap
);

    controlPkg::wbControl outcome;

    // Retirement choice, valid while retireStep is high
    always_comb begin
        outcome = '0;
        if (op.opClass == controlPkg::clsIllegal) begin
            outcome.epcWrite = 1'b1;
            outcome.cause = controlPkg::causeIllegal;
        end else if (overflow && op.trapsOnOverflow) begin
            outcome.epcWrite = 1'b1;
            outcome.cause = controlPkg::causeOverflow;
        end else begin
            outcome.regWrite = 1'b1;
            outcome.regDst = op.regDst;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb <= '0;
            trap <= 1'b0;
        end else if (retireStep) begin
            wb <= outcome;
            // EPC capture and redirect request go together
            trap <= outcome.epcWrite;
        end else begin
            wb <= '0;
            trap <= 1'b0;
        end
    end

    // A trapped instruction never reaches the register file
    writeOrTrap: assert property (@(posedge clock) disable iff (reset)
        !(wb.regWrite && wb.epcWrite));

    // Trap only answers the sequencer's retire pulse
    trapAfterRetire: assert property (@(posedge clock) disable iff (reset)
        trap |-> $past(retireStep));

endmodule

/* hw/execSequencer.sv */
`timescale 1ns/1ps

module execSequencer #(
    parameter int MemLatency = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  controlPkg::decodedOp op,
    input  logic                 trap,
    output controlPkg::dpControl dp,
    output logic                 retireStep
);

    localparam int CountWidth = $clog2(MemLatency + 1);
    localparam logic [CountWidth-1:0] LastWait = CountWidth'(MemLatency);

    typedef enum logic [3:0] {
        stIdle, stFetch, stMemWait, stRegRead, stBranch, stDecode,
        stExecute, stRetire, stWriteback, stExcRedirect
    } stepType;

    stepType               step;
    stepType               nextStep;
    logic [CountWidth-1:0] waitCount;
    logic [CountWidth-1:0] nextWaitCount;
    controlPkg::dpControl  nextDp;

    always_comb begin
        nextStep = step;
        nextWaitCount = waitCount;
        case (step)
            // Held here during reset
            stIdle: nextStep = stFetch;
            stFetch: begin
                nextStep = stMemWait;
                nextWaitCount = CountWidth'(1);
            end
            stMemWait: begin
                if (waitCount == LastWait) begin
                    nextStep = stRegRead;
                end else begin
                    nextWaitCount = waitCount + 1'b1;
                end
            end
            stRegRead: nextStep = stBranch;
            stBranch: nextStep = stDecode;
            stDecode: nextStep = stExecute;
            stExecute: begin
                // Redirects finish here, everything else retires
                if (op.opClass == controlPkg::clsBreak || op.opClass == controlPkg::clsRte) begin
                    nextStep = stFetch;
                end else begin
                    nextStep = stRetire;
                end
            end
            stRetire: nextStep = stWriteback;
            stWriteback: nextStep = trap ? stExcRedirect : stFetch;
            stExcRedirect: nextStep = stFetch;
            default: nextStep = stIdle;
        endcase
    end

    // Controls for the step about to start
    always_comb begin
        nextDp = '0;
        case (nextStep)
            stFetch, stMemWait, stRegRead: begin
                // pc + 4 stays on the ALU until the PC load
                nextDp.aluSrcA = controlPkg::srcApc;
                nextDp.aluSrcB = controlPkg::srcBfour;
                nextDp.aluOp = controlPkg::aluAdd;
                nextDp.pcSource = controlPkg::pcAluResult;
                nextDp.irWrite = (nextStep == stMemWait) && (nextWaitCount == LastWait);
                nextDp.pcWrite = (nextStep == stMemWait) && (nextWaitCount == LastWait);
                nextDp.regAWrite = (nextStep == stRegRead);
                nextDp.regBWrite = (nextStep == stRegRead);
                nextDp.aluOutWrite = (nextStep == stRegRead);
            end
            stBranch: begin
                nextDp.aluSrcA = controlPkg::srcApc;
                nextDp.aluSrcB = controlPkg::srcBbranchOffset;
                nextDp.aluOp = controlPkg::aluAdd;
            end
            stExecute: begin
                case (op.opClass)
                    controlPkg::clsBreak: begin
                        nextDp.pcWrite = 1'b1;
                        nextDp.pcSource = controlPkg::pcAluResult;
                        nextDp.aluSrcA = controlPkg::srcApc;
                        nextDp.aluSrcB = controlPkg::srcBfour;
                        nextDp.aluOp = controlPkg::aluSub;
                    end
                    controlPkg::clsRte: begin
                        nextDp.pcWrite = 1'b1;
                        nextDp.pcSource = controlPkg::pcEpc;
                    end
                    default: begin
                        nextDp.aluSrcA = controlPkg::srcAregA;
                        nextDp.aluSrcB = op.aluSrcB;
                        nextDp.aluOp = op.aluOp;
                        nextDp.aluOutWrite = 1'b1;
                    end
                endcase
            end
            stExcRedirect: begin
                nextDp.pcWrite = 1'b1;
                nextDp.pcSource = controlPkg::pcExcVector;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= stIdle;
            waitCount <= '0;
            dp <= '0;
            retireStep <= 1'b0;
        end else begin
            step <= nextStep;
            waitCount <= nextWaitCount;
            dp <= nextDp;
            retireStep <= (nextStep == stRetire);
        end
    end

    // IR and PC loads last one cycle, a trap redirect may follow directly
    loadPulse: assert property (@(posedge clock) disable iff (reset)
        (dp.irWrite || dp.pcWrite) |=> !(dp.irWrite || dp.pcWrite) || step == stExcRedirect);

    retirePulse: assert property (@(posedge clock) disable iff (reset)
        retireStep |=> !retireStep);

endmodule

/* hw/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  controlPkg::instrWord instr,
    output controlPkg::decodedOp op
);

    always_comb begin
        // Anything not matched below stays illegal
        op = '0;
        op.opClass = controlPkg::clsIllegal;
        op.aluOp = controlPkg::aluAdd;
        op.aluSrcB = controlPkg::srcBregB;
        op.regDst = controlPkg::dstRd;
        op.trapsOnOverflow = 1'b0;

        if (instr.rType.opcode == controlPkg::opR) begin
            case (instr.rType.funct)
                controlPkg::functAdd: begin
                    op.opClass = controlPkg::clsAluReg;
                    op.trapsOnOverflow = 1'b1;
                end
                controlPkg::functSub: begin
                    op.opClass = controlPkg::clsAluReg;
                    op.aluOp = controlPkg::aluSub;
                    op.trapsOnOverflow = 1'b1;
                end
                controlPkg::functAnd: begin
                    op.opClass = controlPkg::clsAluReg;
                    op.aluOp = controlPkg::aluAnd;
                end
                controlPkg::functBreak: begin
                    op.opClass = controlPkg::clsBreak;
                end
                controlPkg::functRte: begin
                    op.opClass = controlPkg::clsRte;
                end
                default: ;
            endcase
        end else begin
            // Same word seen as opcode plus 16-bit immediate
            case (instr.iType.opcode)
                controlPkg::opAddi: begin
                    op.opClass = controlPkg::clsAluImm;
                    op.aluSrcB = controlPkg::srcBimm;
                    op.regDst = controlPkg::dstRt;
                    op.trapsOnOverflow = 1'b1;
                end
                controlPkg::opAddiu: begin
                    // Unsigned add never traps
                    op.opClass = controlPkg::clsAluImm;
                    op.aluSrcB = controlPkg::srcBimm;
                    op.regDst = controlPkg::dstRt;
                end
                default: ;
            endcase
        end
    end

endmodule

/* hw/controlPkg.sv */
package controlPkg;

    // Field views of one instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] immediate;
    } iTypeFields;

    // Low half is funct for R-type and offset for I-type
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

    // Opcodes
    localparam logic [5:0] opR     = 6'b000000;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opAddiu = 6'b001001;

    // R-type funct codes
    localparam logic [5:0] functAdd   = 6'b100000;
    localparam logic [5:0] functSub   = 6'b100010;
    localparam logic [5:0] functAnd   = 6'b100100;
    localparam logic [5:0] functBreak = 6'b001101;
    localparam logic [5:0] functRte   = 6'b010011;

    typedef enum logic [2:0] {
        clsAluReg, clsAluImm, clsBreak, clsRte, clsIllegal
    } opClassType;

    typedef enum logic [2:0] {
        aluAdd = 3'b001,
        aluSub = 3'b010,
        aluAnd = 3'b011
    } aluOpType;

    typedef enum logic [1:0] {
        srcApc   = 2'b01,
        srcAregA = 2'b10
    } aluSrcAType;

    typedef enum logic [1:0] {
        srcBimm          = 2'b00,
        srcBfour         = 2'b01,
        srcBregB         = 2'b10,
        srcBbranchOffset = 2'b11
    } aluSrcBType;

    typedef enum logic [1:0] {
        pcAluResult = 2'b01,
        pcExcVector = 2'b10,
        pcEpc       = 2'b11
    } pcSourceType;

    typedef enum logic [1:0] {
        dstRt = 2'b01,
        dstRd = 2'b11
    } regDstType;

    typedef enum logic {causeOverflow, causeIllegal} excCause;

    typedef struct packed {
        opClassType opClass;
        aluOpType   aluOp;
        aluSrcBType aluSrcB;
        regDstType  regDst;
        logic       trapsOnOverflow;
    } decodedOp;

    // Datapath strobes and selects
    typedef struct packed {
        logic        irWrite;
        logic        pcWrite;
        pcSourceType pcSource;
        aluSrcAType  aluSrcA;
        aluSrcBType  aluSrcB;
        aluOpType    aluOp;
        logic        aluOutWrite;
        logic        regAWrite;
        logic        regBWrite;
    } dpControl;

    typedef struct packed {
        logic      regWrite;
        regDstType regDst;
        logic      epcWrite;
        excCause   cause;
    } wbControl;

endpackage
